/* Makefile */
VERILATOR ?= verilator
TOP       := ex_tb
FILELIST  := sim.f
FLAGS     := --binary --timing --assert
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* ex_alu.sv */
//****************************************
// combinational; shifts use rs2 bits 4:0
// result is zero for ops outside the alu
//****************************************
`timescale 1ns/100ps

module ex_alu (
    input  ex_pkg::aluop_t op_i,
    input  ex_pkg::word_t  rs1_val_i,
    input  ex_pkg::word_t  rs2_val_i,
    output ex_pkg::word_t  result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;
    word_t      logic_res;
    word_t      cmp_res;
    word_t      shift_res;
    word_t      arith_res;

    assign shamt = rs2_val_i[4:0];

    // logic class
    always_comb begin
        case (op_i)
            OP_AND:  logic_res = rs1_val_i & rs2_val_i;
            OP_OR:   logic_res = rs1_val_i | rs2_val_i;
            OP_XOR:  logic_res = rs1_val_i ^ rs2_val_i;
            default: logic_res = '0;
        endcase
    end

    // set-less-than, signed and unsigned
    always_comb begin
        case (op_i)
            OP_SLT:  cmp_res = word_t'($signed(rs1_val_i) < $signed(rs2_val_i));
            OP_SLTU: cmp_res = word_t'(rs1_val_i < rs2_val_i);
            default: cmp_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SLL:  shift_res = rs1_val_i << shamt;
            OP_SRL:  shift_res = rs1_val_i >> shamt;
            OP_SRA:  shift_res = word_t'($signed(rs1_val_i) >>> shamt);
            OP_LUI:  shift_res = rs2_val_i;     // immediate already in place
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            OP_ADD:  arith_res = rs1_val_i + rs2_val_i;
            OP_SUB:  arith_res = rs1_val_i - rs2_val_i;
            default: arith_res = '0;
        endcase
    end

    // at most one class is nonzero for a given op
    assign result_o = logic_res | cmp_res | shift_res | arith_res;

endmodule

/* ex_branch.sv */
//****************************************
// combinational branch, jump and address unit
// unsigned branches use a plain unsigned compare
//****************************************
`timescale 1ns/100ps

module ex_branch (
    input  ex_pkg::aluop_t op_i,
    input  ex_pkg::word_t  pc_i,
    input  ex_pkg::inst_t  inst_i,
    input  ex_pkg::word_t  rs1_val_i,
    input  ex_pkg::word_t  rs2_val_i,
    output logic           branch_flag_o,
    output ex_pkg::word_t  branch_addr_o,
    output ex_pkg::word_t  link_o,
    output ex_pkg::word_t  mem_addr_o
);
    import ex_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    logic  cond_taken;

    // sign-extended immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // conditional branch outcome
    always_comb begin
        case (op_i)
            OP_BEQ:  cond_taken = (rs1_val_i == rs2_val_i);
            OP_BNE:  cond_taken = (rs1_val_i != rs2_val_i);
            OP_BLT:  cond_taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
            OP_BGE:  cond_taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
            OP_BLTU: cond_taken = (rs1_val_i < rs2_val_i);
            OP_BGEU: cond_taken = (rs1_val_i >= rs2_val_i);
            default: cond_taken = 1'b0;
        endcase
    end

    always_comb begin
        branch_flag_o = cond_taken;
        branch_addr_o = cond_taken ? pc_i + imm_b : '0;
        link_o        = '0;
        mem_addr_o    = '0;
        case (op_i)
            OP_JAL: begin
                branch_flag_o = 1'b1;
                branch_addr_o = pc_i + imm_j;
                link_o        = pc_i + 32'd4;
            end
            OP_JALR: begin
                branch_flag_o = 1'b1;
                branch_addr_o = (rs1_val_i + imm_i) & ~32'd1;   // lsb cleared
                link_o        = pc_i + 32'd4;
            end
            OP_LOAD:  mem_addr_o = rs1_val_i + imm_i;
            OP_STORE: mem_addr_o = rs1_val_i + imm_s;
            default: ;
        endcase
    end

endmodule

/* ex_issue.sv */
//****************************************
// wishbone classic slave, ack one cycle after stb
// ack is withheld while the result fifo is full
//****************************************
`timescale 1ns/100ps

module ex_issue (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            req_cyc_i,
    input  logic            req_stb_i,
    input  ex_pkg::ex_req_t req_dat_i,
    output logic            req_ack_o,
    input  logic            fifo_full_i,
    output logic            push_o,
    output ex_pkg::ex_res_t push_dat_o
);
    import ex_pkg::*;

    word_t   alu_res;
    word_t   link;
    word_t   branch_addr;
    word_t   mem_addr;
    logic    branch_flag;
    logic    accept;
    logic    ack_q;
    ex_res_t res_d;
    ex_res_t res_q;

    ex_alu alu_i (
        .op_i      (req_dat_i.op),
        .rs1_val_i (req_dat_i.rs1_val),
        .rs2_val_i (req_dat_i.rs2_val),
        .result_o  (alu_res)
    );

    ex_branch branch_i (
        .op_i          (req_dat_i.op),
        .pc_i          (req_dat_i.pc),
        .inst_i        (req_dat_i.inst),
        .rs1_val_i     (req_dat_i.rs1_val),
        .rs2_val_i     (req_dat_i.rs2_val),
        .branch_flag_o (branch_flag),
        .branch_addr_o (branch_addr),
        .link_o        (link),
        .mem_addr_o    (mem_addr)
    );

    always_comb begin
        res_d.rd          = req_dat_i.rd;
        res_d.wreg        = req_dat_i.wreg;
        res_d.wdata       = (req_dat_i.op == OP_JAL || req_dat_i.op == OP_JALR) ? link : alu_res;
        res_d.branch_flag = branch_flag;
        res_d.branch_addr = branch_addr;
        res_d.mem_addr    = mem_addr;
    end

    // no second ack while the current one is still out
    assign accept = req_cyc_i && req_stb_i && !ack_q && !fifo_full_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // sampled while the master still holds the request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q <= res_d;
        end
    end

    assign req_ack_o  = ack_q;
    assign push_o     = ack_q;  // write lands in the ack cycle
    assign push_dat_o = res_q;

endmodule

/* ex_pkg.sv */
//****************************************
// shared types and codes of the execute unit
// opcode values are fixed, test data stores them as numbers
//****************************************

package ex_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 5;

    typedef logic [XLEN-1:0]       word_t;      // register value or address
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [ALUOP_W-1:0]    aluop_t;

    // operation codes
    localparam aluop_t OP_NOP   = 5'd0;
    localparam aluop_t OP_AND   = 5'd1;
    localparam aluop_t OP_OR    = 5'd2;
    localparam aluop_t OP_XOR   = 5'd3;
    localparam aluop_t OP_SLT   = 5'd4;
    localparam aluop_t OP_SLTU  = 5'd5;
    localparam aluop_t OP_SLL   = 5'd6;
    localparam aluop_t OP_SRL   = 5'd7;
    localparam aluop_t OP_SRA   = 5'd8;
    localparam aluop_t OP_LUI   = 5'd9;     // rs2 carries the shifted immediate
    localparam aluop_t OP_ADD   = 5'd10;
    localparam aluop_t OP_SUB   = 5'd11;
    localparam aluop_t OP_BEQ   = 5'd12;
    localparam aluop_t OP_BNE   = 5'd13;
    localparam aluop_t OP_BLT   = 5'd14;
    localparam aluop_t OP_BGE   = 5'd15;
    localparam aluop_t OP_BLTU  = 5'd16;
    localparam aluop_t OP_BGEU  = 5'd17;
    localparam aluop_t OP_JAL   = 5'd18;
    localparam aluop_t OP_JALR  = 5'd19;
    localparam aluop_t OP_LOAD  = 5'd20;
    localparam aluop_t OP_STORE = 5'd21;

    // result queue sizing
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    // execute request, as decoded upstream
    typedef struct packed {
        aluop_t    op;
        word_t     pc;
        inst_t     inst;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rd;
        logic      wreg;
    } ex_req_t;

    // execute result, towards writeback
    typedef struct packed {
        reg_addr_t rd;
        logic      wreg;
        word_t     wdata;
        logic      branch_flag;
        word_t     branch_addr;     // zero unless branch_flag
        word_t     mem_addr;        // zero unless load or store
    } ex_res_t;

endpackage

/* ex_props.sv */
//****************************************
// handshake rules on both wishbone ports
//****************************************
`timescale 1ns/100ps

module ex_props (
    input logic clk_i,
    input logic arst_n_i,
    input logic req_cyc_i,
    input logic req_stb_i,
    input logic req_ack_o,
    input logic res_cyc_o,
    input logic res_stb_o,
    input logic res_ack_i
);

    // master keeps stb up until the slave answers
    req_stb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_stb_i && !req_ack_o |=> req_stb_i)
        else $error("request stb dropped before ack");

    res_stb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        res_stb_o && !res_ack_i |=> res_stb_o)
        else $error("result stb dropped before ack");

    req_ack_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_ack_o |-> req_cyc_i && req_stb_i)
        else $error("request ack outside a bus cycle");

    res_ack_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        res_ack_i |-> res_cyc_o && res_stb_o)
        else $error("result ack outside a bus cycle");

    res_quiet_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !res_stb_o)
        else $error("result stb during reset");

endmodule

bind ex_top ex_props props_i (.*);

/* ex_result_fifo.sv */
//****************************************
// result queue, FIFO_DEPTH entries
// caller never pushes on full or pops on empty
//****************************************
`timescale 1ns/100ps

module ex_result_fifo (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            push_i,
    input  ex_pkg::ex_res_t push_dat_i,
    input  logic            pop_i,
    output ex_pkg::ex_res_t head_o,
    output logic            full_o,
    output logic            empty_o
);
    import ex_pkg::*;

    ex_res_t   mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;

    function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
        return (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_dat_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= ptr_next(wr_ptr);
            if (pop_i)  rd_ptr <= ptr_next(rd_ptr);
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // both or neither, count holds
            endcase
        end
    end

    assign head_o  = mem[rd_ptr];
    assign full_o  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign empty_o = (count == '0);

endmodule

/* ex_retire.sv */
//****************************************
// wishbone classic master towards writeback
// stb drops for one cycle between results
//****************************************
`timescale 1ns/100ps

module ex_retire (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            empty_i,
    input  ex_pkg::ex_res_t head_i,
    output logic            pop_o,
    output logic            res_cyc_o,
    output logic            res_stb_o,
    output ex_pkg::ex_res_t res_dat_o,
    input  logic            res_ack_i
);

    typedef enum logic {
        RET_IDLE,
        RET_BUSY
    } ret_state_t;

    ret_state_t state;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= RET_IDLE;
        end else begin
            case (state)
                RET_IDLE: if (!empty_i)  state <= RET_BUSY;
                RET_BUSY: if (res_ack_i) state <= RET_IDLE;
                default:                 state <= RET_IDLE;
            endcase
        end
    end

    assign res_cyc_o = (state == RET_BUSY);
    assign res_stb_o = (state == RET_BUSY);
    assign res_dat_o = head_i;      // head is stable until the pop

    // consume the head on the ack cycle
    assign pop_o = (state == RET_BUSY) && res_ack_i;

endmodule

/* ex_tb.sv */
//****************************************
// reads ex_testdata.txt from the run directory
// sink acks after 0..3 cycles, lfsr seeded 28
//****************************************
`timescale 1ns/100ps

module ex_tb;
    import ex_pkg::*;

    logic    clk_i;
    logic    arst_n_i;
    logic    req_cyc_i;
    logic    req_stb_i;
    ex_req_t req_dat_i;
    logic    req_ack_o;
    logic    res_cyc_o;
    logic    res_stb_o;
    ex_res_t res_dat_o;
    logic    res_ack_i;

    ex_res_t   exp_q[$];
    int        num_q[$];
    int        err_count = 0;
    int        test_count = 0;
    int        sent = 0;
    bit        timed_out = 0;
    logic [7:0] lfsr = 8'd28;

    ex_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // fibonacci lfsr, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // result checker, fifo level monitor and random-delay sink
    int acks = 0;
    int pops = 0;
    int pops_old = 0;
    int delay = 0;

    always @(negedge clk_i) begin
        ex_res_t exp;
        int      num;
        int      errs_before;
        if (arst_n_i) begin
            if (req_ack_o) begin
                // entries pushed minus entries popped before the accepting edge
                if (acks - pops_old >= FIFO_DEPTH) begin
                    $display("request acknowledged while the result FIFO was full");
                    err_count++;
                end
                acks++;
            end
            pops_old = pops;
            if (res_ack_i) begin
                // the edge just passed took the result, ack is a one-cycle pulse
                res_ack_i <= 1'b0;
                lfsr = lfsr_step(lfsr);
                delay = lfsr[0];
                lfsr = lfsr_step(lfsr);
                delay = delay * 2 + lfsr[0];
            end else if (res_stb_o) begin
                if (delay != 0) begin
                    delay--;
                end else begin
                    pops++;     // pop lands on the next rising edge
                    if (exp_q.size() == 0) begin
                        $display("result arrived with no request outstanding");
                        err_count++;
                    end else begin
                        exp = exp_q.pop_front();
                        num = num_q.pop_front();
                        errs_before = err_count;
                        check_reg("res_dat_o.rd", res_dat_o.rd, exp.rd);
                        check_flag("res_dat_o.wreg", res_dat_o.wreg, exp.wreg);
                        check_word("res_dat_o.wdata", res_dat_o.wdata, exp.wdata);
                        check_flag("res_dat_o.branch_flag", res_dat_o.branch_flag,
                                   exp.branch_flag);
                        check_word("res_dat_o.branch_addr", res_dat_o.branch_addr,
                                   exp.branch_addr);
                        check_word("res_dat_o.mem_addr", res_dat_o.mem_addr, exp.mem_addr);
                        test_count++;
                        $display("test %0d request %0d: %s", test_count, num,
                                 (err_count == errs_before) ? "ok" : "failed");
                    end
                    res_ack_i <= 1'b1;
                end
            end
        end
    end

    initial begin
        int    fd;
        int    n;
        int    waited;
        int    errs_before;
        string line;
        logic [31:0] f_op, f_pc, f_inst, f_rs1, f_rs2, f_rd, f_wreg;
        logic [31:0] e_wdata, e_flag, e_baddr, e_maddr;
        ex_res_t exp;

        arst_n_i  = 1'b0;
        req_cyc_i = 1'b0;
        req_stb_i = 1'b0;
        req_dat_i = '0;
        res_ack_i = 1'b0;
        repeat (8) @(negedge clk_i);
        arst_n_i = 1'b1;

        // idle bus after reset
        errs_before = err_count;
        repeat (5) begin
            @(negedge clk_i);
            check_flag("req_ack_o", req_ack_o, 1'b0);
            check_flag("res_cyc_o", res_cyc_o, 1'b0);
            check_flag("res_stb_o", res_stb_o, 1'b0);
        end
        test_count++;
        $display("test %0d idle after reset: %s", test_count,
                 (err_count == errs_before) ? "ok" : "failed");

        fd = $fopen("ex_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open ex_testdata.txt");
            err_count++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_op, f_pc, f_inst,
                            f_rs1, f_rs2, f_rd, f_wreg, e_wdata, e_flag, e_baddr, e_maddr);
                if (n != 11) begin
                    $display("malformed line in ex_testdata.txt");
                    err_count++;
                    continue;
                end
                exp.rd          = reg_addr_t'(f_rd);
                exp.wreg        = f_wreg[0];
                exp.wdata       = e_wdata;
                exp.branch_flag = e_flag[0];
                exp.branch_addr = e_baddr;
                exp.mem_addr    = e_maddr;
                sent++;
                exp_q.push_back(exp);
                num_q.push_back(sent);
                req_dat_i.op      = aluop_t'(f_op);
                req_dat_i.pc      = f_pc;
                req_dat_i.inst    = f_inst;
                req_dat_i.rs1_val = f_rs1;
                req_dat_i.rs2_val = f_rs2;
                req_dat_i.rd      = reg_addr_t'(f_rd);
                req_dat_i.wreg    = f_wreg[0];
                req_cyc_i = 1'b1;
                req_stb_i = 1'b1;
                waited = 0;
                @(negedge clk_i);
                while (!req_ack_o && waited < 200) begin
                    @(negedge clk_i);
                    waited++;
                end
                if (!req_ack_o) begin
                    $display("timed out waiting for request ack on request %0d", sent);
                    timed_out = 1;
                end else begin
                    @(negedge clk_i);   // request held through the ack edge
                end
            end
            $fclose(fd);
        end
        req_cyc_i = 1'b0;
        req_stb_i = 1'b0;

        // drain the remaining results
        waited = 0;
        while (exp_q.size() != 0 && waited < 500 && !timed_out) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d results never arrived", exp_q.size());
            timed_out = 1;
        end
        repeat (5) @(negedge clk_i);

        $display("%0d tests, %0d requests, %0d errors", test_count, sent, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* ex_testdata.txt */
# op pc inst rs1 rs2 rd wreg | expected: wdata branch_flag branch_addr mem_addr
# all fields hex, op codes as in the package
01 00000000 00000000 f0f0ffff 0ff0f00f 01 1 00f0f00f 0 00000000 00000000
02 00000000 00000000 12340000 00005678 02 1 12345678 0 00000000 00000000
03 00000000 00000000 aaaa5555 ffff0000 03 1 55555555 0 00000000 00000000
04 00000000 00000000 ffffffff 00000001 04 1 00000001 0 00000000 00000000
05 00000000 00000000 ffffffff 00000001 05 1 00000000 0 00000000 00000000
06 00000000 00000000 00000003 00000024 06 1 00000030 0 00000000 00000000
07 00000000 00000000 80000000 0000001f 07 1 00000001 0 00000000 00000000
08 00000000 00000000 80000000 00000004 08 1 f8000000 0 00000000 00000000
09 00000000 00000000 00000000 abcde000 09 1 abcde000 0 00000000 00000000
0a 00000000 00000000 7fffffff 00000001 0a 1 80000000 0 00000000 00000000
0b 00000000 00000000 00000000 00000001 0b 1 ffffffff 0 00000000 00000000
0c 00001000 00000800 00000005 00000005 00 0 00000000 1 00001010 00000000
0d 00001000 00000800 00000005 00000005 00 0 00000000 0 00000000 00000000
0e 00001000 fe000c80 80000000 00000001 00 0 00000000 1 00000ff8 00000000
0f 00001000 fe000c80 80000000 7fffffff 00 0 00000000 0 00000000 00000000
10 00001000 00000800 80000000 7fffffff 00 0 00000000 0 00000000 00000000
11 00001000 00000800 80000000 7fffffff 00 0 00000000 1 00001010 00000000
10 00001000 fe000c80 00000001 ffffffff 00 0 00000000 1 00000ff8 00000000
12 00002000 10000000 00000000 00000000 01 1 00002004 1 00002100 00000000
13 00003000 00400000 00004001 00000000 05 1 00003004 1 00004004 00000000
14 00000000 ffc00000 00001000 00000000 0a 1 00000000 0 00000000 00000ffc
15 00000000 fe000800 00002000 12345678 00 0 00000000 0 00000000 00001ff0
15 00000000 02000200 00000100 00000000 00 0 00000000 0 00000000 00000124
00 00000000 00000000 12345678 9abcdef0 00 0 00000000 0 00000000 00000000

/* ex_top.sv */
//****************************************
// execute unit top, issue to fifo to retire
// results leave in request order
//****************************************
`timescale 1ns/100ps

module ex_top (
    input  logic            clk_i,
    input  logic            arst_n_i,
    // request port, wishbone slave
    input  logic            req_cyc_i,
    input  logic            req_stb_i,
    input  ex_pkg::ex_req_t req_dat_i,
    output logic            req_ack_o,
    // result port, wishbone master
    output logic            res_cyc_o,
    output logic            res_stb_o,
    output ex_pkg::ex_res_t res_dat_o,
    input  logic            res_ack_i
);
    import ex_pkg::*;

    logic    fifo_full;
    logic    fifo_empty;
    logic    push;
    logic    pop;
    ex_res_t push_dat;
    ex_res_t head;

    ex_issue issue_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_cyc_i   (req_cyc_i),
        .req_stb_i   (req_stb_i),
        .req_dat_i   (req_dat_i),
        .req_ack_o   (req_ack_o),
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .push_dat_o  (push_dat)
    );

    ex_result_fifo fifo_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .push_dat_i (push_dat),
        .pop_i      (pop),
        .head_o     (head),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty)
    );

    ex_retire retire_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .empty_i   (fifo_empty),
        .head_i    (head),
        .pop_o     (pop),
        .res_cyc_o (res_cyc_o),
        .res_stb_o (res_stb_o),
        .res_dat_o (res_dat_o),
        .res_ack_i (res_ack_i)
    );

endmodule

/* sim.f */
ex_pkg.sv
ex_alu.sv
ex_branch.sv
ex_issue.sv
ex_result_fifo.sv
ex_retire.sv
ex_top.sv
ex_props.sv
ex_tb.sv
